// File: rtl/ls_settings.svh
`ifndef LS_SETTINGS_SVH
`define LS_SETTINGS_SVH

`define XLEN                64

// values of instr[6:2]
`define OPC_LOAD            5'b00000
`define OPC_STORE           5'b01000
`define OPC_SYSTEM          5'b11100

`define CSR_MSTATUS         12'h300
`define CSR_MIE             12'h304
`define CSR_MTVEC           12'h305
`define CSR_MSCRATCH        12'h340
`define CSR_MEPC            12'h341
`define CSR_MCAUSE          12'h342
`define CSR_MIP             12'h344

// byte offsets inside the clint window
`define CLINT_MTIMECMP_OFS  16'h4000
`define CLINT_MTIME_OFS     16'hbff8

`define AXI_RESP_OKAY       2'b00
`define AXI_RESP_SLVERR     2'b10

`endif

// File: rtl/ls_pkg.sv
`default_nettype none

`include "ls_settings.svh"

package ls_pkg;

    typedef struct packed {
        logic [11:0]        csr;        // funct12 or csr address
        logic [4:0]         rs1;        // uimm for the immediate csr forms
        logic [2:0]         funct3;
        logic [4:0]         rd;
        logic [6:0]         opcode;
    } itype_t;

    typedef struct packed {
        logic [6:0]         imm_hi;
        logic [4:0]         rs2;
        logic [4:0]         rs1;
        logic [2:0]         funct3;
        logic [4:0]         imm_lo;
        logic [6:0]         opcode;
    } stype_t;

    typedef union packed {
        itype_t             i;
        stype_t             s;
    } rv_instr_u;

    typedef struct packed {
        logic               rd_en;
        logic               wr_en;
        logic [1:0]         size;       // byte, half, word, double
        logic               unsigned_ld;
        logic [`XLEN-1:0]   wr_data;    // already on its byte lane
        logic [7:0]         wr_mask;
    } mem_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]   addr;
        logic               rd_en;
        logic               wr_en;
        logic [`XLEN-1:0]   wr_data;
        logic [7:0]         wr_mask;
        logic [2:0]         size;
    } sram_req_t;

    typedef struct packed {
        logic [`XLEN-1:0]   addr;
        logic               valid;
    } axil_aw_t;

    typedef struct packed {
        logic [`XLEN-1:0]   data;
        logic [7:0]         strb;
        logic               valid;
    } axil_w_t;

    typedef struct packed {
        logic [1:0]         resp;
        logic               valid;
    } axil_b_t;

    typedef struct packed {
        logic [`XLEN-1:0]   addr;
        logic               valid;
    } axil_ar_t;

    typedef struct packed {
        logic [`XLEN-1:0]   data;
        logic [1:0]         resp;
        logic               valid;
    } axil_r_t;

endpackage

`default_nettype wire

// File: rtl/ls_ctr.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_settings.svh"

module ls_ctr import ls_pkg::*; (
    input  rv_instr_u           instr_i,
    input  logic [`XLEN-1:0]    rs2_i,
    input  logic [2:0]          addr_lo_i,
    output mem_req_t            req_o
);

    logic           is_load;
    logic           is_store;
    logic [1:0]     st_size;

    assign is_load  = (instr_i.i.opcode[6:2] == `OPC_LOAD);
    assign is_store = (instr_i.s.opcode[6:2] == `OPC_STORE);
    assign st_size  = instr_i.s.funct3[1:0];

    always_comb begin
        req_o       = '0;
        req_o.rd_en = is_load;
        req_o.wr_en = is_store;
        if (is_load) begin
            req_o.size        = instr_i.i.funct3[1:0];
            req_o.unsigned_ld = instr_i.i.funct3[2];   // lbu, lhu, lwu
        end else if (is_store) begin
            req_o.size = st_size;
            case (st_size)
                2'd0: begin
                    req_o.wr_data = {8{rs2_i[7:0]}};
                    req_o.wr_mask = 8'h01 << addr_lo_i;
                end
                2'd1: begin
                    req_o.wr_data = {4{rs2_i[15:0]}};
                    req_o.wr_mask = 8'h03 << {addr_lo_i[2:1], 1'b0};
                end
                2'd2: begin
                    req_o.wr_data = {2{rs2_i[31:0]}};
                    req_o.wr_mask = 8'h0f << {addr_lo_i[2], 2'b00};
                end
                default: begin
                    req_o.wr_data = rs2_i;
                    req_o.wr_mask = 8'hff;
                end
            endcase
        end
    end

    // replicated data lets the mask alone pick the lane

endmodule

`default_nettype wire

// File: rtl/lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_settings.svh"

module lsu import ls_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  mem_req_t            req_i,
    input  logic [`XLEN-1:0]    addr_i,
    input  logic [`XLEN-1:0]    alures_i,
    input  logic                advance_i,
    output sram_req_t           sram_req_o,
    input  logic                sram_rd_valid_i,
    input  logic                sram_wr_ok_i,
    input  logic [`XLEN-1:0]    sram_rd_data_i,
    output logic [`XLEN-1:0]    ls_res_o,
    output logic                ls_not_ok_o
);

    logic                   done;       // response seen for the current instruction
    logic                   resp;
    logic                   rd_resp;
    logic [`XLEN-1:0]       lane;
    logic [`XLEN-1:0]       ld_ext;
    logic [`XLEN-1:0]       ld_res;

    assign sram_req_o.addr    = addr_i;
    assign sram_req_o.rd_en   = req_i.rd_en & ~done;
    assign sram_req_o.wr_en   = req_i.wr_en & ~done;
    assign sram_req_o.wr_data = req_i.wr_data;
    assign sram_req_o.wr_mask = req_i.wr_mask;
    assign sram_req_o.size    = {1'b0, req_i.size};

    assign rd_resp = sram_req_o.rd_en & sram_rd_valid_i;
    assign resp    = rd_resp | (sram_req_o.wr_en & sram_wr_ok_i);

    assign ls_not_ok_o = (req_i.rd_en | req_i.wr_en) & ~done;

    assign lane = sram_rd_data_i >> {addr_i[2:0], 3'b000};  // addressed byte to bit 0

    always_comb begin
        case (req_i.size)
            2'd0: begin
                if (req_i.unsigned_ld) begin
                    ld_ext = {{(`XLEN-8){1'b0}}, lane[7:0]};
                end else begin
                    ld_ext = {{(`XLEN-8){lane[7]}}, lane[7:0]};
                end
            end
            2'd1: begin
                if (req_i.unsigned_ld) begin
                    ld_ext = {{(`XLEN-16){1'b0}}, lane[15:0]};
                end else begin
                    ld_ext = {{(`XLEN-16){lane[15]}}, lane[15:0]};
                end
            end
            2'd2: begin
                if (req_i.unsigned_ld) begin
                    ld_ext = {{(`XLEN-32){1'b0}}, lane[31:0]};
                end else begin
                    ld_ext = {{(`XLEN-32){lane[31]}}, lane[31:0]};
                end
            end
            default: begin
                ld_ext = lane;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            done <= 1'b0;
        end else if (resp) begin
            done <= 1'b1;
        end else if (advance_i) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_resp) begin
            ld_res <= ld_ext;
        end
    end

    assign ls_res_o = req_i.rd_en ? ld_res : alures_i;  // non-loads pass the alu result

endmodule

`default_nettype wire

// File: rtl/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_settings.svh"

module csr_file import ls_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [`XLEN-1:0]    pc_i,
    input  rv_instr_u           instr_i,
    input  logic [`XLEN-1:0]    wr_data_i,
    input  logic                trap_i,
    input  logic                advance_i,
    input  logic                timer_int_i,
    output logic [`XLEN-1:0]    csr_data_o,
    output logic [`XLEN-1:0]    mtvec_o,
    output logic [`XLEN-1:0]    mepc_o,
    output logic                in_intr_ls_o
);

    logic [`XLEN-1:0]   mstatus;
    logic [`XLEN-1:0]   mie;
    logic [`XLEN-1:0]   mip;
    logic [`XLEN-1:0]   mtvec;
    logic [`XLEN-1:0]   mepc;
    logic [`XLEN-1:0]   mcause;
    logic [`XLEN-1:0]   mscratch;
    logic [`XLEN-1:0]   src;
    logic [`XLEN-1:0]   new_val;
    logic [11:0]        csr_addr;
    logic               is_system;
    logic               is_csr_op;
    logic               is_mret;
    logic               csr_we;
    logic               instr_valid;

    assign csr_addr    = instr_i.i.csr;
    assign is_system   = (instr_i.i.opcode[6:2] == `OPC_SYSTEM);
    assign is_csr_op   = is_system & (instr_i.i.funct3[1:0] != 2'b00);
    assign is_mret     = is_system & (instr_i.i.funct3 == 3'b000) & (csr_addr == 12'h302);
    assign instr_valid = (instr_i != '0);  // all zero word is a bubble

    assign src    = instr_i.i.funct3[2] ? {{(`XLEN-5){1'b0}}, instr_i.i.rs1} : wr_data_i;
    assign csr_we = is_csr_op & ((instr_i.i.funct3[1:0] == 2'b01) | (instr_i.i.rs1 != 5'd0));

    assign mip          = {{(`XLEN-8){1'b0}}, timer_int_i, 7'b0};  // mtip
    assign in_intr_ls_o = instr_valid & mstatus[3] & mie[7] & mip[7];

    always_comb begin
        case (csr_addr)
            `CSR_MSTATUS:  csr_data_o = mstatus;
            `CSR_MIE:      csr_data_o = mie;
            `CSR_MIP:      csr_data_o = mip;
            `CSR_MTVEC:    csr_data_o = mtvec;
            `CSR_MEPC:     csr_data_o = mepc;
            `CSR_MCAUSE:   csr_data_o = mcause;
            `CSR_MSCRATCH: csr_data_o = mscratch;
            default:       csr_data_o = '0;
        endcase
    end

    always_comb begin
        case (instr_i.i.funct3[1:0])
            2'b01:   new_val = src;
            2'b10:   new_val = csr_data_o | src;
            default: new_val = csr_data_o & ~src;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (advance_i) begin
            if (in_intr_ls_o) begin
                mepc       <= pc_i;
                mcause     <= {1'b1, {(`XLEN-5){1'b0}}, 4'd7};  // machine timer
                mstatus[7] <= mstatus[3];
                mstatus[3] <= 1'b0;
            end else if (trap_i) begin
                mepc       <= pc_i;
                mcause     <= {{(`XLEN-4){1'b0}}, 4'd11};  // ecall from m-mode
                mstatus[7] <= mstatus[3];
                mstatus[3] <= 1'b0;
            end else if (is_mret) begin
                mstatus[3] <= mstatus[7];
                mstatus[7] <= 1'b1;
            end else if (csr_we) begin
                case (csr_addr)
                    `CSR_MSTATUS:  mstatus  <= new_val;
                    `CSR_MIE:      mie      <= new_val;
                    `CSR_MTVEC:    mtvec    <= new_val;
                    `CSR_MEPC:     mepc     <= new_val;
                    `CSR_MCAUSE:   mcause   <= new_val;
                    `CSR_MSCRATCH: mscratch <= new_val;
                    default:       mscratch <= mscratch;  // mip is read only
                endcase
            end
        end
    end

    assign mtvec_o = mtvec;
    assign mepc_o  = mepc;

endmodule

`default_nettype wire

// File: rtl/clint.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_settings.svh"

module clint import ls_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  axil_aw_t    aw_i,
    output logic        aw_ready_o,
    input  axil_w_t     w_i,
    output logic        w_ready_o,
    output axil_b_t     b_o,
    input  logic        b_ready_i,
    input  axil_ar_t    ar_i,
    output logic        ar_ready_o,
    output axil_r_t     r_o,
    input  logic        r_ready_i,
    output logic        timer_int_o
);

    logic [`XLEN-1:0]   mtime;
    logic [`XLEN-1:0]   mtimecmp;
    logic               wr_fire;
    logic               rd_fire;
    logic               wr_cmp;
    logic               wr_time;
    logic [15:0]        rd_ofs;

    function automatic logic [`XLEN-1:0] merge_strb(input logic [`XLEN-1:0] old_v,
                                                    input logic [`XLEN-1:0] new_v,
                                                    input logic [7:0] strb);
        logic [`XLEN-1:0] res;
        res = old_v;
        for (int i = 0; i < 8; i++) begin
            if (strb[i]) begin
                res[i*8 +: 8] = new_v[i*8 +: 8];
            end
        end
        return res;
    endfunction

    // aw and w are taken together, only when no b is outstanding
    assign wr_fire    = aw_i.valid & w_i.valid & ~b_o.valid;
    assign aw_ready_o = wr_fire;
    assign w_ready_o  = wr_fire;
    assign wr_cmp     = wr_fire & (aw_i.addr[15:0] == `CLINT_MTIMECMP_OFS);
    assign wr_time    = wr_fire & (aw_i.addr[15:0] == `CLINT_MTIME_OFS);

    assign ar_ready_o = ~r_o.valid;
    assign rd_fire    = ar_i.valid & ~r_o.valid;
    assign rd_ofs     = ar_i.addr[15:0];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime       <= '0;
            mtimecmp    <= '1;
            timer_int_o <= 1'b0;
        end else begin
            mtime <= wr_time ? merge_strb(mtime, w_i.data, w_i.strb) : mtime + 1'b1;
            if (wr_cmp) begin
                mtimecmp <= merge_strb(mtimecmp, w_i.data, w_i.strb);
            end
            timer_int_o <= (mtime >= mtimecmp);
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            b_o <= '0;
        end else if (wr_fire) begin
            b_o.valid <= 1'b1;
            b_o.resp  <= (wr_cmp | wr_time) ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
        end else if (b_ready_i) begin
            b_o.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            r_o <= '0;
        end else if (rd_fire) begin
            r_o.valid <= 1'b1;
            case (rd_ofs)
                `CLINT_MTIMECMP_OFS: begin
                    r_o.data <= mtimecmp;
                    r_o.resp <= `AXI_RESP_OKAY;
                end
                `CLINT_MTIME_OFS: begin
                    r_o.data <= mtime;
                    r_o.resp <= `AXI_RESP_OKAY;
                end
                default: begin
                    r_o.data <= '0;
                    r_o.resp <= `AXI_RESP_SLVERR;
                end
            endcase
        end else if (r_ready_i) begin
            r_o.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rtl/ls_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_settings.svh"

module ls_stage import ls_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic [`XLEN-1:0]    pc_i,
    input  rv_instr_u           instr_i,
    input  logic [`XLEN-1:0]    alures_i,
    input  logic [`XLEN-1:0]    rs2_i,
    input  logic [`XLEN-1:0]    wb_data_i,
    input  logic                ld_csr_hazard_i,
    input  logic                trap_ls_i,
    input  logic                stall_n_i,
    input  logic                if_stall_n_i,
    output logic [`XLEN-1:0]    ls_res_o,
    output logic [`XLEN-1:0]    csr_data_o,
    output logic [`XLEN-1:0]    mtvec_o,
    output logic [`XLEN-1:0]    mepc_o,
    output logic                ls_not_ok_o,
    output logic                in_intr_ls_o,
    output sram_req_t           sram_req_o,
    input  logic                sram_rd_valid_i,
    input  logic                sram_wr_ok_i,
    input  logic [`XLEN-1:0]    sram_rd_data_i,
    input  axil_aw_t            aw_i,
    output logic                aw_ready_o,
    input  axil_w_t             w_i,
    output logic                w_ready_o,
    output axil_b_t             b_o,
    input  logic                b_ready_i,
    input  axil_ar_t            ar_i,
    output logic                ar_ready_o,
    output axil_r_t             r_o,
    input  logic                r_ready_i
);

    mem_req_t           mem_req;
    logic [`XLEN-1:0]   csr_wr_data;
    logic               csr_stall_n;
    logic               advance;
    logic               timer_int;

    assign csr_wr_data = ld_csr_hazard_i ? wb_data_i : alures_i;  // load result not in regfile yet
    assign csr_stall_n = in_intr_ls_o ? if_stall_n_i : stall_n_i;
    assign advance     = ~ls_not_ok_o & csr_stall_n;

    ls_ctr u_ls_ctr (
        .instr_i        (instr_i),
        .rs2_i          (rs2_i),
        .addr_lo_i      (alures_i[2:0]),
        .req_o          (mem_req)
    );

    lsu u_lsu (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .req_i          (mem_req),
        .addr_i         (alures_i),
        .alures_i       (alures_i),
        .advance_i      (advance),
        .sram_req_o     (sram_req_o),
        .sram_rd_valid_i(sram_rd_valid_i),
        .sram_wr_ok_i   (sram_wr_ok_i),
        .sram_rd_data_i (sram_rd_data_i),
        .ls_res_o       (ls_res_o),
        .ls_not_ok_o    (ls_not_ok_o)
    );

    csr_file u_csr_file (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pc_i           (pc_i),
        .instr_i        (instr_i),
        .wr_data_i      (csr_wr_data),
        .trap_i         (trap_ls_i),
        .advance_i      (advance),
        .timer_int_i    (timer_int),
        .csr_data_o     (csr_data_o),
        .mtvec_o        (mtvec_o),
        .mepc_o         (mepc_o),
        .in_intr_ls_o   (in_intr_ls_o)
    );

    clint u_clint (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .aw_i           (aw_i),
        .aw_ready_o     (aw_ready_o),
        .w_i            (w_i),
        .w_ready_o      (w_ready_o),
        .b_o            (b_o),
        .b_ready_i      (b_ready_i),
        .ar_i           (ar_i),
        .ar_ready_o     (ar_ready_o),
        .r_o            (r_o),
        .r_ready_i      (r_ready_i),
        .timer_int_o    (timer_int)
    );

endmodule

`default_nettype wire

// File: testbench/ls_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ls_settings.svh"

module ls_stage_tb import ls_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200 * 8 + 400 + 2000;  // instructions, axi phases, margin

    logic               clk = 1'b0;
    logic               rst_n_i;
    logic [`XLEN-1:0]   pc_i, alures_i, rs2_i, wb_data_i;
    rv_instr_u          instr_i;
    logic               ld_csr_hazard_i, trap_ls_i, stall_n_i, if_stall_n_i;
    logic [`XLEN-1:0]   ls_res_o, csr_data_o, mtvec_o, mepc_o;
    logic               ls_not_ok_o, in_intr_ls_o;
    sram_req_t          sram_req_o;
    logic               sram_rd_valid_i, sram_wr_ok_i;
    logic [`XLEN-1:0]   sram_rd_data_i;
    axil_aw_t           aw_i;
    axil_w_t            w_i;
    axil_ar_t           ar_i;
    axil_b_t            b_o;
    axil_r_t            r_o;
    logic               aw_ready_o, w_ready_o, b_ready_i, ar_ready_o, r_ready_i;

    logic [63:0]        mem [256];      // sram model contents
    logic [63:0]        shadow [256];
    logic [15:0]        lfsr = 16'd12389;
    logic               busy, pulse;
    logic [1:0]         delay;
    int                 req_count, resp_count, cycles, exec_count, exp_size;
    logic [63:0]        cap_res, cap_csr, cap_mtvec, cap_mepc;
    logic               cap_intr;

    ls_stage UUT (.*);

    always #4 clk = ~clk;

    function automatic logic [63:0] rnd(input int n);
        logic [63:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], b};
            v    = {v[62:0], b};
        end
        return v;
    endfunction

    function automatic logic [63:0] load_ref(input logic [63:0] dbl, input int ofs,
                                             input int size, input logic uns);
        int          nbits;
        logic [63:0] v;
        nbits = 8 << size;
        v     = dbl >> (ofs * 8);
        for (int i = 0; i < 64; i++) begin
            if (i >= nbits) v[i] = uns ? 1'b0 : v[nbits-1];
        end
        return v;
    endfunction

    function automatic logic [63:0] store_ref(input logic [63:0] old, input int ofs,
                                              input int size, input logic [63:0] data);
        logic [63:0] v;
        v = old;
        for (int i = 0; i < (1 << size); i++) begin
            v[(ofs+i)*8 +: 8] = data[i*8 +: 8];
        end
        return v;
    endfunction

    function automatic logic [63:0] csr_ref(input logic [2:0] f3, input logic [63:0] old,
                                            input logic [63:0] src, input logic [4:0] rs1);
        if (f3[1:0] != 2'b01 && rs1 == 5'd0) return old;   // s/c with x0 or zero uimm
        case (f3[1:0])
            2'b01:   return src;
            2'b10:   return old | src;
            default: return old & ~src;
        endcase
    endfunction

    task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // sram: one request taken, answered after a random delay with a one-cycle pulse
    always @(posedge clk) begin
        if (pulse) begin
            sram_rd_valid_i <= 1'b0;
            sram_wr_ok_i    <= 1'b0;
            pulse           <= 1'b0;
            busy            <= 1'b0;
            resp_count      <= resp_count + 1;
        end else if (busy) begin
            if (delay == 0) begin
                pulse <= 1'b1;
                if (sram_req_o.rd_en) begin
                    sram_rd_valid_i <= 1'b1;
                    sram_rd_data_i  <= mem[sram_req_o.addr[10:3]];
                end else begin
                    sram_wr_ok_i <= 1'b1;
                    for (int b = 0; b < 8; b++) begin
                        if (sram_req_o.wr_mask[b])
                            mem[sram_req_o.addr[10:3]][b*8 +: 8] = sram_req_o.wr_data[b*8 +: 8];
                    end
                end
            end else begin
                delay <= delay - 1'b1;
            end
        end else if (rst_n_i && (sram_req_o.rd_en || sram_req_o.wr_en)) begin
            compare("sram request size", sram_req_o.size, exp_size);
            busy      <= 1'b1;
            delay     <= rnd(2);
            req_count <= req_count + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    task automatic exec(input logic [31:0] ins, input logic [63:0] pc, input logic [63:0] alu,
                        input logic [63:0] rs2v, input logic [63:0] wb, input logic haz,
                        input logic trap);
        logic is_mem;
        is_mem     = (ins[6:2] == `OPC_LOAD) || (ins[6:2] == `OPC_STORE);
        req_count  = 0;
        resp_count = 0;
        exec_count = exec_count + 1;
        @(posedge clk);
        instr_i         <= ins;
        pc_i            <= pc;
        alures_i        <= alu;
        rs2_i           <= rs2v;
        wb_data_i       <= wb;
        ld_csr_hazard_i <= haz;
        trap_ls_i       <= trap;
        stall_n_i       <= exec_count[0];   // some instructions start stalled
        if_stall_n_i    <= exec_count[1];
        forever begin
            @(negedge clk);
            if (is_mem) compare("busy flag", ls_not_ok_o, resp_count == 0);
            if (!ls_not_ok_o && (in_intr_ls_o ? if_stall_n_i : stall_n_i)) begin
                cap_res   = ls_res_o;
                cap_csr   = csr_data_o;
                cap_intr  = in_intr_ls_o;
                cap_mtvec = mtvec_o;
                cap_mepc  = mepc_o;
                break;
            end
            if (!ls_not_ok_o) begin
                @(posedge clk);
                stall_n_i    <= 1'b1;   // held for one cycle once the unit is ready
                if_stall_n_i <= 1'b1;
            end
        end
        if (is_mem) compare("sram request count", req_count, 1);
    endtask

    function automatic logic [31:0] enc_csr(input logic [11:0] a, input logic [4:0] rs1,
                                            input logic [2:0] f3);
        return {a, rs1, f3, 5'd4, 7'b1110011};
    endfunction

    task automatic axi_write(input logic [63:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, output logic [1:0] resp);
        @(posedge clk);
        aw_i.addr <= addr;
        aw_i.valid <= 1'b1;
        w_i.data  <= data;
        w_i.strb  <= strb;
        w_i.valid <= 1'b1;
        b_ready_i <= 1'b1;
        do @(negedge clk); while (!(aw_ready_o && w_ready_o));
        @(posedge clk);
        aw_i.valid <= 1'b0;
        w_i.valid  <= 1'b0;
        do @(negedge clk); while (!b_o.valid);
        resp = b_o.resp;
        @(posedge clk);
        b_ready_i <= 1'b0;
    endtask

    task automatic axi_read(input logic [63:0] addr, output logic [63:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        ar_i.addr  <= addr;
        ar_i.valid <= 1'b1;
        r_ready_i  <= 1'b1;
        do @(negedge clk); while (!ar_ready_o);
        @(posedge clk);
        ar_i.valid <= 1'b0;
        do @(negedge clk); while (!r_o.valid);
        data = r_o.data;
        resp = r_o.resp;
        @(posedge clk);
        r_ready_i <= 1'b0;
    endtask

    initial begin
        logic [63:0] addr, rs2v, sh_scratch, sh_mtvec, src, d0, d1;
        logic [11:0] csr_a;
        logic [4:0]  rs1f;
        logic [2:0]  f3;
        logic [1:0]  resp;
        int          size, ofs, idx;
        logic        uns, st;
        rst_n_i = 1'b0;
        instr_i = 32'h0000_0013;   // nop
        {pc_i, alures_i, rs2_i, wb_data_i} = '0;
        {ld_csr_hazard_i, trap_ls_i} = '0;
        stall_n_i = 1'b1;
        if_stall_n_i = 1'b1;
        {sram_rd_valid_i, sram_wr_ok_i, busy, pulse} = '0;
        sram_rd_data_i = '0;
        delay = '0;
        {aw_i, w_i, ar_i, b_ready_i, r_ready_i} = '0;
        cycles = 0;
        exec_count = 0;
        exp_size = 0;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = {32'(i) * 32'h9e37_79b9, ~(32'(i) * 32'h85eb_ca6b)};
            shadow[i] = mem[i];
        end
        repeat (10) @(posedge clk);
        rst_n_i <= 1'b1;

        for (int n = 0; n < 100; n++) begin
            st   = rnd(1);
            size = rnd(2);
            exp_size = size;
            uns  = (size < 3) ? rnd(1) : 1'b0;
            idx  = rnd(8);
            ofs  = rnd(3) & ~((1 << size) - 1);
            addr = 64'(idx * 8 + ofs);
            rs2v = rnd(64);
            if (st) begin
                exec({7'd0, 5'd3, 5'd1, 3'(size), 5'd0, 7'b0100011}, 64'h100 + 4*n, addr,
                     rs2v, '0, 1'b0, 1'b0);
                shadow[idx] = store_ref(shadow[idx], ofs, size, rs2v);
                compare("stored double", mem[idx], shadow[idx]);
            end else begin
                exec({12'd0, 5'd1, uns, 2'(size), 5'd2, 7'b0000011}, 64'h100 + 4*n, addr,
                     rs2v, '0, 1'b0, 1'b0);
                compare("load result", cap_res, load_ref(shadow[idx], ofs, size, uns));
            end
        end

        sh_scratch = '0;
        sh_mtvec   = '0;
        for (int n = 0; n < 24; n++) begin
            csr_a = n[0] ? `CSR_MTVEC : `CSR_MSCRATCH;
            f3    = 3'((n / 2) % 3 + 1) | (n >= 12 ? 3'b100 : 3'b000);
            src   = rnd(64);
            rs1f  = f3[2] ? 5'(rnd(5)) : 5'd1;
            if (f3[2]) src = 64'(rs1f);
            exec(enc_csr(csr_a, rs1f, f3), '0, src, '0, '0, 1'b0, 1'b0);
            compare("mtvec_o", cap_mtvec, sh_mtvec);
            compare("ls_res_o passthrough", cap_res, src);
            if (n[0]) begin
                compare("csr old mtvec", cap_csr, sh_mtvec);
                sh_mtvec = csr_ref(f3, sh_mtvec, src, rs1f);
            end else begin
                compare("csr old mscratch", cap_csr, sh_scratch);
                sh_scratch = csr_ref(f3, sh_scratch, src, rs1f);
            end
        end

        // forwarded write-back data
        exec(enc_csr(`CSR_MSCRATCH, 5'd1, 3'b001), '0, 64'haaaa, '0, 64'h5a5a_1234, 1'b1, 1'b0);
        exec(enc_csr(`CSR_MSCRATCH, 5'd0, 3'b010), '0, '0, '0, '0, 1'b0, 1'b0);
        compare("forwarded mscratch", cap_csr, 64'h5a5a_1234);
        compare("mtvec_o after csr ops", cap_mtvec, sh_mtvec);

        axi_write(`CLINT_MTIMECMP_OFS, 64'h1122_3344_5566_7788, 8'h0f, resp);
        compare("mtimecmp write resp", resp, `AXI_RESP_OKAY);
        axi_read(`CLINT_MTIMECMP_OFS, d0, resp);
        compare("mtimecmp read resp", resp, `AXI_RESP_OKAY);
        compare("mtimecmp masked", d0, 64'hffff_ffff_5566_7788);
        axi_read(`CLINT_MTIME_OFS, d0, resp);
        axi_read(`CLINT_MTIME_OFS, d1, resp);
        compare("mtime read resp", resp, `AXI_RESP_OKAY);
        compare("mtime increases", d1 > d0, 1'b1);
        axi_read(64'h0100, d0, resp);
        compare("unmapped read resp", resp, `AXI_RESP_SLVERR);
        compare("unmapped read data", d0, 64'h0);
        axi_write(64'h0100, 64'h1, 8'hff, resp);
        compare("unmapped write resp", resp, `AXI_RESP_SLVERR);
        axi_write(`CLINT_MTIMECMP_OFS, 64'h0, 8'hff, resp);

        exec(enc_csr(`CSR_MIE, 5'd1, 3'b010), '0, 64'h80, '0, '0, 1'b0, 1'b0);
        exec(enc_csr(`CSR_MSTATUS, 5'd1, 3'b010), '0, 64'h8, '0, '0, 1'b0, 1'b0);
        exec(32'h0000_0013, 64'h8000_0040, '0, '0, '0, 1'b0, 1'b0);
        compare("in_intr_ls_o", cap_intr, 1'b1);
        exec(enc_csr(`CSR_MCAUSE, 5'd0, 3'b010), '0, '0, '0, '0, 1'b0, 1'b0);
        compare("mepc after interrupt", cap_mepc, 64'h8000_0040);
        compare("mcause interrupt", cap_csr, {1'b1, 59'd0, 4'd7});

        exec(enc_csr(`CSR_MIE, 5'd1, 3'b011), '0, 64'h80, '0, '0, 1'b0, 1'b0);
        exec(enc_csr(`CSR_MSTATUS, 5'd1, 3'b010), '0, 64'h8, '0, '0, 1'b0, 1'b0);
        exec(32'h0000_0073, 64'h8000_0080, '0, '0, '0, 1'b0, 1'b1);   // ecall
        exec(enc_csr(`CSR_MCAUSE, 5'd0, 3'b010), '0, '0, '0, '0, 1'b0, 1'b0);
        compare("mcause ecall", cap_csr, 64'd11);
        compare("mepc after ecall", cap_mepc, 64'h8000_0080);
        exec(32'h3020_0073, '0, '0, '0, '0, 1'b0, 1'b0);               // mret
        exec(enc_csr(`CSR_MSTATUS, 5'd0, 3'b010), '0, '0, '0, '0, 1'b0, 1'b0);
        compare("mstatus.mie after mret", cap_csr[3], 1'b1);
        exec(32'h0000_0013, '0, '0, '0, '0, 1'b0, 1'b0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+rtl
rtl/ls_pkg.sv
rtl/ls_ctr.sv
rtl/lsu.sv
rtl/csr_file.sv
rtl/clint.sv
rtl/ls_stage.sv
testbench/ls_stage_tb.sv
